//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and instruction word
`define CPU_WORD_W 32

// register file geometry
`define CPU_REG_AW 5
`define CPU_REG_N  32

`define CPU_ZERO_WORD 32'h0000_0000

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,  // r-type, decoded by funct
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL = 6'b000000,
        F_SRL = 6'b000010,
        F_SRA = 6'b000011,
        F_AND = 6'b100100,
        F_OR  = 6'b100101,
        F_XOR = 6'b100110,
        F_NOR = 6'b100111
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT
    } alu_sel_e;

    typedef struct packed {
        opcode_e                op;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [`CPU_REG_AW-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                op;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    // one instruction word, two views
    typedef union packed {
        r_fmt_t                 r;
        i_fmt_t                 i;
        logic [`CPU_WORD_W-1:0] raw;
    } inst_u;

    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        alu_sel_e               alu_sel;
        logic [`CPU_WORD_W-1:0] op1;
        logic [`CPU_WORD_W-1:0] op2;
        logic [`CPU_REG_AW-1:0] waddr;
        logic                   we;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`CPU_REG_AW-1:0] addr;
        logic [`CPU_WORD_W-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

//--- verilog/inst_port.sv
`timescale 1ns/1ps
`default_nettype none

module inst_port (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            inst_req_i,
    input  cpu_pkg::inst_u  inst_i,
    output logic            inst_ack_o,
    output logic            inst_valid_o,
    output cpu_pkg::inst_u  inst_o
);

    logic           ack_q;
    logic           valid_q;
    cpu_pkg::inst_u inst_q;
    logic           take;

    // new transaction only when ack is low
    assign take = inst_req_i && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= take;                 // one cycle per handshake
            if (take) begin
                ack_q <= 1'b1;
            end else if (!inst_req_i) begin
                ack_q <= 1'b0;               // req dropped, release
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            inst_q <= inst_i;
        end
    end

    assign inst_ack_o   = ack_q;
    assign inst_valid_o = valid_q;
    assign inst_o       = inst_q;

endmodule

`default_nettype wire

//--- verilog/id.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module id (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   inst_valid_i,
    input  cpu_pkg::inst_u         inst_i,
    output logic [`CPU_REG_AW-1:0] raddr1_o,
    output logic [`CPU_REG_AW-1:0] raddr2_o,
    input  logic [`CPU_WORD_W-1:0] rdata1_i,
    input  logic [`CPU_WORD_W-1:0] rdata2_i,
    output cpu_pkg::id_ex_t        id_ex_o
);

    cpu_pkg::id_ex_t id_ex_d;
    cpu_pkg::id_ex_t id_ex_q;
    logic            is_rtype;

    assign is_rtype = (inst_i.r.op == cpu_pkg::OP_SPECIAL);

    // both views share rs/rt positions
    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = inst_valid_i;
        id_ex_d.alu_op  = cpu_pkg::ALU_NOP;
        id_ex_d.alu_sel = cpu_pkg::SEL_NOP;
        id_ex_d.waddr   = is_rtype ? inst_i.r.rd : inst_i.i.rt;

        if (inst_i.raw != `CPU_ZERO_WORD) begin
            case (inst_i.r.op)
                cpu_pkg::OP_SPECIAL: begin
                    id_ex_d.we = 1'b1;
                    case (inst_i.r.funct)
                        cpu_pkg::F_OR:  id_ex_d.alu_op = cpu_pkg::ALU_OR;
                        cpu_pkg::F_AND: id_ex_d.alu_op = cpu_pkg::ALU_AND;
                        cpu_pkg::F_XOR: id_ex_d.alu_op = cpu_pkg::ALU_XOR;
                        cpu_pkg::F_NOR: id_ex_d.alu_op = cpu_pkg::ALU_NOR;
                        cpu_pkg::F_SLL: id_ex_d.alu_op = cpu_pkg::ALU_SLL;
                        cpu_pkg::F_SRL: id_ex_d.alu_op = cpu_pkg::ALU_SRL;
                        cpu_pkg::F_SRA: id_ex_d.alu_op = cpu_pkg::ALU_SRA;
                        default:        id_ex_d.we     = 1'b0;  // unknown funct
                    endcase
                end
                cpu_pkg::OP_ORI: begin
                    id_ex_d.alu_op = cpu_pkg::ALU_OR;
                    id_ex_d.we     = 1'b1;
                end
                cpu_pkg::OP_ANDI: begin
                    id_ex_d.alu_op = cpu_pkg::ALU_AND;
                    id_ex_d.we     = 1'b1;
                end
                cpu_pkg::OP_XORI: begin
                    id_ex_d.alu_op = cpu_pkg::ALU_XOR;
                    id_ex_d.we     = 1'b1;
                end
                cpu_pkg::OP_LUI: begin
                    id_ex_d.alu_op = cpu_pkg::ALU_LUI;
                    id_ex_d.we     = 1'b1;
                end
                default: ;
            endcase
        end

        case (id_ex_d.alu_op)
            cpu_pkg::ALU_NOP: id_ex_d.alu_sel = cpu_pkg::SEL_NOP;
            cpu_pkg::ALU_SLL,
            cpu_pkg::ALU_SRL,
            cpu_pkg::ALU_SRA: id_ex_d.alu_sel = cpu_pkg::SEL_SHIFT;
            default:          id_ex_d.alu_sel = cpu_pkg::SEL_LOGIC;
        endcase

        // operand selection
        if (id_ex_d.alu_sel == cpu_pkg::SEL_SHIFT) begin
            id_ex_d.op1 = rdata2_i;                         // shift source is rt
            id_ex_d.op2 = {{(`CPU_WORD_W-5){1'b0}}, inst_i.r.shamt};
        end else if (is_rtype) begin
            id_ex_d.op1 = rdata1_i;
            id_ex_d.op2 = rdata2_i;
        end else if (id_ex_d.alu_op == cpu_pkg::ALU_LUI) begin
            id_ex_d.op1 = `CPU_ZERO_WORD;
            id_ex_d.op2 = {inst_i.i.imm, 16'h0000};
        end else begin
            id_ex_d.op1 = rdata1_i;
            id_ex_d.op2 = {{(`CPU_WORD_W-16){1'b0}}, inst_i.i.imm};  // zero extend
        end
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
        if (rst_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.we    <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`CPU_REG_AW-1:0] raddr1_i,
    input  logic [`CPU_REG_AW-1:0] raddr2_i,
    output logic [`CPU_WORD_W-1:0] rdata1_o,
    output logic [`CPU_WORD_W-1:0] rdata2_o,
    input  cpu_pkg::wb_t           wb_i
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_N];
    logic                   wr_en;

    assign wr_en = wb_i.valid && wb_i.we && (wb_i.addr != '0);  // r0 never written

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 0; k < `CPU_REG_N; k++) begin
                regs[k] <= `CPU_ZERO_WORD;
            end
        end else if (wr_en) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    function automatic logic [`CPU_WORD_W-1:0] read_port(
        input logic [`CPU_REG_AW-1:0] addr
    );
        logic [`CPU_WORD_W-1:0] val;
        if (addr == '0) begin
            val = `CPU_ZERO_WORD;
        end else if (wr_en && (wb_i.addr == addr)) begin
            val = wb_i.data;                 // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

`default_nettype wire

//--- verilog/ex.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module ex (
    input  logic            clk,
    input  logic            rst_i,
    input  cpu_pkg::id_ex_t id_ex_i,
    output cpu_pkg::wb_t    wb_o
);

    logic [`CPU_WORD_W-1:0] logic_res;
    logic [`CPU_WORD_W-1:0] shift_res;
    logic [`CPU_WORD_W-1:0] alu_res;
    logic [4:0]             shift_cnt;
    cpu_pkg::wb_t           wb_d;
    cpu_pkg::wb_t           wb_q;

    assign shift_cnt = id_ex_i.op2[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            cpu_pkg::ALU_OR:  logic_res = id_ex_i.op1 | id_ex_i.op2;
            cpu_pkg::ALU_AND: logic_res = id_ex_i.op1 & id_ex_i.op2;
            cpu_pkg::ALU_XOR: logic_res = id_ex_i.op1 ^ id_ex_i.op2;
            cpu_pkg::ALU_NOR: logic_res = ~(id_ex_i.op1 | id_ex_i.op2);
            cpu_pkg::ALU_LUI: logic_res = id_ex_i.op2;       // immediate already shifted
            default:          logic_res = `CPU_ZERO_WORD;
        endcase
    end

    always_comb begin
        case (id_ex_i.alu_op)
            cpu_pkg::ALU_SLL: shift_res = id_ex_i.op1 << shift_cnt;
            cpu_pkg::ALU_SRL: shift_res = id_ex_i.op1 >> shift_cnt;
            cpu_pkg::ALU_SRA: shift_res = $signed(id_ex_i.op1) >>> shift_cnt;  // sign fill
            default:          shift_res = `CPU_ZERO_WORD;
        endcase
    end

    // result class select
    always_comb begin
        case (id_ex_i.alu_sel)
            cpu_pkg::SEL_LOGIC: alu_res = logic_res;
            cpu_pkg::SEL_SHIFT: alu_res = shift_res;
            default:            alu_res = `CPU_ZERO_WORD;
        endcase
    end

    always_comb begin
        wb_d.valid = id_ex_i.valid;
        wb_d.we    = id_ex_i.we;
        wb_d.addr  = id_ex_i.waddr;
        wb_d.data  = alu_res;
    end

    always_ff @(posedge clk) begin
        wb_q <= wb_d;
        if (rst_i) begin
            wb_q.valid <= 1'b0;
            wb_q.we    <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_core (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           inst_req_i,
    input  cpu_pkg::inst_u inst_i,
    output logic           inst_ack_o,
    output cpu_pkg::wb_t   wb_o
);

    logic                   inst_valid;
    cpu_pkg::inst_u         inst;
    logic [`CPU_REG_AW-1:0] raddr1;
    logic [`CPU_REG_AW-1:0] raddr2;
    logic [`CPU_WORD_W-1:0] rdata1;
    logic [`CPU_WORD_W-1:0] rdata2;
    cpu_pkg::id_ex_t        id_ex;
    cpu_pkg::wb_t           wb;

    inst_port u_inst_port (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_req_i   (inst_req_i),
        .inst_i       (inst_i),
        .inst_ack_o   (inst_ack_o),
        .inst_valid_o (inst_valid),
        .inst_o       (inst)
    );

    id u_id (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .id_ex_o      (id_ex)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb)             // commit one cycle after ex
    );

    ex u_ex (
        .clk     (clk),
        .rst_i   (rst_i),
        .id_ex_i (id_ex),
        .wb_o    (wb)
    );

    assign wb_o = wb;

endmodule

`default_nettype wire

//--- tests/cpu_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_props (
    input logic         clk,
    input logic         rst_i,
    input logic         req_i,
    input logic         ack_i,
    input cpu_pkg::wb_t wb_i
);

    int fail_count = 0;  // failing assertions so far

    ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    // ack released only after req drops
    ack_holds: assert property (@(posedge clk) disable iff (rst_i)
        ack_i && req_i |=> ack_i)
        else begin
            fail_count++;
            $error("ack fell while req still high");
        end

    wb_latency: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |=> !wb_i.valid ##1 wb_i.valid)
        else begin
            fail_count++;
            $error("write-back did not follow ack by two cycles");
        end

    reset_state: assert property (@(posedge clk)
        rst_i |=> !ack_i && !wb_i.valid)
        else begin
            fail_count++;
            $error("ack or write-back valid high after reset");
        end

endmodule

bind cpu_core cpu_core_props u_cpu_core_props (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (inst_req_i),
    .ack_i (inst_ack_o),
    .wb_i  (wb_o)
);

`default_nettype wire

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_core_tb;

    localparam int N_PAT     = 24;
    localparam int CLK_HALF  = 10;
    localparam int WD_CYCLES = N_PAT * 10 + 50;

    logic           clk;
    logic           rst_i;
    logic           inst_req_i;
    cpu_pkg::inst_u inst_i;
    logic           inst_ack_o;
    cpu_pkg::wb_t   wb_o;

    // four words per pattern: instruction, we, addr, data
    logic [`CPU_WORD_W-1:0] pat_mem [4*N_PAT];
    logic [31:0]            rng_state;
    int                     wb_count   = 0;
    int                     sent_count = 0;

    cpu_core u_cpu_core (
        .clk        (clk),
        .rst_i      (rst_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .wb_o       (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_pkg::wb_t expected_wb(input int idx);
        cpu_pkg::wb_t w;
        w.valid = 1'b1;
        w.we    = pat_mem[4*idx+1][0];
        w.addr  = pat_mem[4*idx+2][`CPU_REG_AW-1:0];
        w.data  = pat_mem[4*idx+3];
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t exp, input int idx);
        if (got.we !== exp.we) begin
            abort_run($sformatf("CHECK FAILED wb_o.we (pattern %0d): got %h expected %h",
                                idx, got.we, exp.we));
        end else if (got.addr !== exp.addr) begin
            abort_run($sformatf("CHECK FAILED wb_o.addr (pattern %0d): got %h expected %h",
                                idx, got.addr, exp.addr));
        end else if (got.data !== exp.data) begin
            abort_run($sformatf("CHECK FAILED wb_o.data (pattern %0d): got %h expected %h",
                                idx, got.data, exp.data));
        end
    endtask

    // one four-phase transaction
    task automatic send_inst(input cpu_pkg::inst_u word);
        inst_i     = word;
        inst_req_i = 1'b1;
        sent_count++;
        @(negedge clk);
        while (inst_ack_o !== 1'b1) @(negedge clk);
        inst_req_i = 1'b0;
        rng_state  = xorshift32(rng_state);
        inst_i     = rng_state;              // junk, port must hold its copy
        @(negedge clk);
        while (inst_ack_o !== 1'b0) @(negedge clk);
    endtask

    initial begin : stimulus
        int gap;
        rst_i      = 1'b1;
        inst_req_i = 1'b0;
        inst_i     = '0;
        rng_state  = 32'he027;
        $readmemh("tests/cpu_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[0]) || $isunknown(pat_mem[4*N_PAT-1])) begin
            abort_run("pattern file tests/cpu_patterns.hex is missing or too short");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        for (int n = 0; n < N_PAT; n++) begin
            rng_state = xorshift32(rng_state);
            gap = (n % 2 == 1) ? 0 : int'(rng_state[1:0]);  // odd ones back to back
            repeat (gap) @(negedge clk);
            send_inst(pat_mem[4*n]);
        end
        while (wb_count < N_PAT) @(negedge clk);
        repeat (4) @(negedge clk);           // room for a stray duplicate
        $display("Testbench passed");
        $finish;
    end

    initial begin : wb_monitor
        cpu_pkg::wb_t exp;
        forever begin
            @(negedge clk);
            if (wb_o.valid === 1'b1) begin
                if (wb_count >= sent_count || wb_count >= N_PAT) begin
                    abort_run("write-back seen with no instruction waiting for it");
                end else begin
                    exp = expected_wb(wb_count);
                    check_wb(wb_o, exp, wb_count);
                    wb_count++;
                end
            end
        end
    end

    initial begin : prop_watch
        wait (u_cpu_core.u_cpu_core_props.fail_count != 0);
        abort_run("a handshake, latency or reset assertion on the core failed");
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: only %0d of %0d write-backs arrived",
                            wb_count, N_PAT));
    end

endmodule

`default_nettype wire

//--- tests/cpu_patterns.hex
// columns: instruction word, expected we, expected destination, expected result
// rows in issue order, odd rows are sent back to back
34011234 1 01 00001234  // ori  r1, r0, 0x1234
3C02F0F0 1 02 F0F00000  // lui  r2, 0xf0f0
3803A5A5 1 03 0000A5A5  // xori r3, r0, 0xa5a5
3863FFFF 1 03 00005A5A  // xori r3, r3, 0xffff
344200FF 1 02 F0F000FF  // ori  r2, r2, 0x00ff
30440F0F 1 04 0000000F  // andi r4, r2, 0x0f0f
00232825 1 05 00005A7E  // or   r5, r1, r3
00A23024 1 06 0000007E  // and  r6, r5, r2
00413826 1 07 F0F012CB  // xor  r7, r2, r1
00E04027 1 08 0F0FED34  // nor  r8, r7, r0
3C098001 1 09 80010000  // lui  r9, 0x8001
00095043 1 0A C0008000  // sra  r10, r9, 1
00095FC3 1 0B FFFFFFFF  // sra  r11, r9, 31
000967C2 1 0C 00000001  // srl  r12, r9, 31
000C6FC0 1 0D 80000000  // sll  r13, r12, 31
000D7000 1 0E 80000000  // sll  r14, r13, 0
000A7842 1 0F 60004000  // srl  r15, r10, 1
000F8003 1 10 60004000  // sra  r16, r15, 0
3420FFFF 1 00 0000FFFF  // ori  r0, r1, 0xffff
00009025 1 12 00000000  // or   r18, r0, r0
00018840 1 11 00002468  // sll  r17, r1, 1
00000000 0 00 00000000  // nop
3253FFFF 1 13 00000000  // andi r19, r18, 0xffff
014BA026 1 14 3FFF7FFF  // xor  r20, r10, r11

//--- vlog.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/inst_port.sv
verilog/id.sv
verilog/regfile.sv
verilog/ex.sv
verilog/cpu_core.sv
tests/cpu_core_props.sv
tests/cpu_core_tb.sv
